//--- rtl/cache_pkg.sv
//--------------------------------------------------------------------------
// Shared types and constants of the direct-mapped lookup cache, used by
// every RTL block and the testbench through scoped names
//--------------------------------------------------------------------------
`default_nettype none

package cache_pkg;

  //--------------------------------------------------------------------------
  // Basic widths
  //--------------------------------------------------------------------------

  // Byte address seen by the requester
  typedef logic [15:0] addr_t;

  // One cache word, which is also the unit of a fill
  typedef logic [31:0] data_t;

  // One write enable per byte of a cache word
  typedef logic [$bits(data_t)/8-1:0] byte_en_t;

  // Byte offset inside a word follows from the word size alone
  localparam int unsigned OFFSET_BITS = $clog2($bits(data_t) / 8);

  // Set count used when the top level is not overridden
  localparam int unsigned NUM_SETS_DEFAULT = 64;

  //--------------------------------------------------------------------------
  // Request and response
  //--------------------------------------------------------------------------

  // Operations a requester may strobe in
  typedef enum logic [1:0] {
    op_lookup = 2'd0,
    op_fill   = 2'd1,
    op_inval  = 2'd2
  } cache_op_e;

  // One request, 54 bits wide
  // Only a fill uses wdata and byte_en
  typedef struct packed {
    cache_op_e op;
    addr_t     addr;
    data_t     wdata;
    byte_en_t  byte_en;
  } cache_req_t;

  // Lookup response, 33 bits wide
  // Data reads as zero on a miss
  typedef struct packed {
    logic  hit;
    data_t data;
  } cache_resp_t;

endpackage

`default_nettype wire

//--- rtl/sram_1rw.sv
//--------------------------------------------------------------------------
// Single-port SRAM with registered read and byte write enables, storing
// one word of the type given by word_t per entry
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sram_1rw #(
  parameter type         word_t      = logic [31:0],
  parameter int unsigned num_entries = 64,
  localparam int unsigned addr_bits  = $clog2(num_entries),
  localparam int unsigned data_bits  = $bits(word_t),
  localparam int unsigned num_bytes  = (data_bits + 7) / 8
) (
  input  wire logic                 clk,
  input  wire logic                 rd_en,
  input  wire logic                 wr_en,
  input  wire logic [addr_bits-1:0] addr,
  input  wire logic [num_bytes-1:0] wr_byte_en,
  input  wire word_t                wr_data,
  output word_t                     rd_data
);

  // Storage is rounded up to whole bytes so every lane has 8 bits
  localparam int unsigned pad_bits = num_bytes * 8;

  logic [pad_bits-1:0] mem [num_entries];
  logic [pad_bits-1:0] wr_word;
  logic [pad_bits-1:0] rd_word;

  // Write data widened to the padded storage width
  assign wr_word = pad_bits'(wr_data);

  //--------------------------------------------------------------------------
  // Read port
  //--------------------------------------------------------------------------

  // The read register keeps its last value on cycles without a read
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_word <= mem[addr];
    end
  end

  // Padding lanes never reach the output
  assign rd_data = word_t'(rd_word[data_bits-1:0]);

  //--------------------------------------------------------------------------
  // Write port
  //--------------------------------------------------------------------------

  // Each byte lane is written on its own enable
  for (genvar b = 0; b < num_bytes; b++) begin : g_byte
    always @(posedge clk) begin
      if (wr_en && wr_byte_en[b]) begin
        mem[addr][b*8 +: 8] <= wr_word[b*8 +: 8];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/tag_array.sv
//--------------------------------------------------------------------------
// Tag store of the cache, tags in an SRAM and valid bits in flops, with
// read results that line up with the data SRAM one cycle after rd_en
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tag_array #(
  parameter int unsigned num_sets   = 64,
  localparam int unsigned index_bits = $clog2(num_sets)
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  rd_en,
  input  wire logic                  wr_en,
  input  wire logic                  clr_en,
  input  wire logic [index_bits-1:0] index,
  input  wire cache_pkg::addr_t      wr_tag,
  output cache_pkg::addr_t           rd_tag,
  output logic                       rd_valid
);

  // A tag is always written whole
  localparam int unsigned tag_bytes = ($bits(cache_pkg::addr_t) + 7) / 8;

  // One valid flag per set
  logic [num_sets-1:0] valid_q;

  //--------------------------------------------------------------------------
  // Tag SRAM
  //--------------------------------------------------------------------------

  // Invalidate leaves the stored tag in place, only the valid flag drops
  sram_1rw #(
    .word_t      (cache_pkg::addr_t),
    .num_entries (num_sets)
  ) i_tag_sram (
    .clk        (clk),
    .rd_en      (rd_en),
    .wr_en      (wr_en),
    .addr       (index),
    .wr_byte_en ({tag_bytes{1'b1}}),
    .wr_data    (wr_tag),
    .rd_data    (rd_tag)
  );

  //--------------------------------------------------------------------------
  // Valid bits
  //--------------------------------------------------------------------------

  // Fill marks the set valid, invalidate clears it
  // The top level never asserts both in one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[index] <= 1'b1;
    end else if (clr_en) begin
      valid_q[index] <= 1'b0;
    end
  end

  // Valid flag read out on the same edge as the SRAM tag
  // Like the SRAM output it holds on idle cycles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else if (rd_en) begin
      rd_valid <= valid_q[index];
    end
  end

endmodule

`default_nettype wire

//--- rtl/hit_check.sv
//--------------------------------------------------------------------------
// Hit checker, holds a lookup for one cycle and compares its tag with the
// tag array output to form the response in the cycle after the request
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module hit_check (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 req_valid,
  input  wire cache_pkg::cache_op_e req_op,
  input  wire cache_pkg::addr_t     req_tag,
  input  wire cache_pkg::addr_t     rd_tag,
  input  wire logic                 rd_valid,
  input  wire cache_pkg::data_t     rd_data,
  output logic                      resp_valid,
  output cache_pkg::cache_resp_t    resp
);

  // Pipeline stage holding the lookup in flight
  logic             lookup_q;
  cache_pkg::addr_t tag_q;
  logic             tag_match;

  //--------------------------------------------------------------------------
  // Request stage
  //--------------------------------------------------------------------------

  // Only lookups enter the stage, fills and invalidates give no response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lookup_q <= 1'b0;
    end else begin
      lookup_q <= req_valid && (req_op == cache_pkg::op_lookup);
    end
  end

  // Tag of the lookup in flight is loaded only on a lookup
  always_ff @(posedge clk) begin
    if (req_valid && (req_op == cache_pkg::op_lookup)) begin
      tag_q <= req_tag;
    end
  end

  //--------------------------------------------------------------------------
  // Compare stage
  //--------------------------------------------------------------------------

  // The arrays were read on the same edge that loaded tag_q
  assign tag_match = (rd_tag == tag_q);

  // Response valid comes straight from the stage register
  assign resp_valid = lookup_q;

  // A hit needs a set that is valid and holds the same tag
  // Data is forced to zero on a miss so stale words never leak out
  always_comb begin
    resp.hit  = lookup_q && rd_valid && tag_match;
    resp.data = resp.hit ? rd_data : '0;
  end

endmodule

`default_nettype wire

//--- rtl/cache_lookup_top.sv
//--------------------------------------------------------------------------
// Top level of the lookup cache, splits the request address and ties the
// tag array, the data SRAM and the hit checker together
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cache_lookup_top #(
  parameter int unsigned num_sets = cache_pkg::NUM_SETS_DEFAULT
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  req_valid,
  input  wire cache_pkg::cache_req_t req,
  output logic                       resp_valid,
  output cache_pkg::cache_resp_t     resp
);

  localparam int unsigned index_bits = $clog2(num_sets);

  logic                  do_lookup;
  logic                  do_fill;
  logic                  do_inval;
  logic [index_bits-1:0] index;
  cache_pkg::addr_t      tag;
  cache_pkg::addr_t      rd_tag;
  logic                  rd_valid;
  cache_pkg::data_t      rd_data;

  //--------------------------------------------------------------------------
  // Request decode
  //--------------------------------------------------------------------------

  // Operations are mutually exclusive, so a cycle never reads and writes
  assign do_lookup = req_valid && (req.op == cache_pkg::op_lookup);
  assign do_fill   = req_valid && (req.op == cache_pkg::op_fill);
  assign do_inval  = req_valid && (req.op == cache_pkg::op_inval);

  // Index sits just above the byte offset, the tag is everything above it
  assign index = req.addr[cache_pkg::OFFSET_BITS +: index_bits];
  assign tag   = req.addr >> (cache_pkg::OFFSET_BITS + index_bits);

  //--------------------------------------------------------------------------
  // Arrays and hit check
  //--------------------------------------------------------------------------

  tag_array #(
    .num_sets (num_sets)
  ) i_tag_array (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_en    (do_lookup),
    .wr_en    (do_fill),
    .clr_en   (do_inval),
    .index    (index),
    .wr_tag   (tag),
    .rd_tag   (rd_tag),
    .rd_valid (rd_valid)
  );

  // Fill merges wdata into the stored word under byte_en
  sram_1rw #(
    .word_t      (cache_pkg::data_t),
    .num_entries (num_sets)
  ) i_data_sram (
    .clk        (clk),
    .rd_en      (do_lookup),
    .wr_en      (do_fill),
    .addr       (index),
    .wr_byte_en (req.byte_en),
    .wr_data    (req.wdata),
    .rd_data    (rd_data)
  );

  hit_check i_hit_check (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_op     (req.op),
    .req_tag    (tag),
    .rd_tag     (rd_tag),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

endmodule

`default_nettype wire

//--- dv/cache_lookup_asserts.sv
//--------------------------------------------------------------------------
// Response timing and SRAM port checks, bound into the cache top level
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cache_lookup_asserts (
  input wire logic                  clk,
  input wire logic                  rst_n,
  input wire logic                  req_valid,
  input wire cache_pkg::cache_req_t req,
  input wire logic                  resp_valid,
  input wire logic                  sram_rd_en,
  input wire logic                  sram_wr_en
);

  logic lookup;

  assign lookup = req_valid && (req.op == cache_pkg::op_lookup);

  // Every lookup is answered on the following cycle
  a_lookup_resp : assert property (@(posedge clk) disable iff (!rst_n)
    lookup |=> resp_valid)
    else $error("lookup without a response one cycle later");

  // A response only ever follows a lookup
  a_resp_source : assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid |-> $past(lookup))
    else $error("response without a lookup on the previous cycle");

  // The single SRAM port never reads and writes together
  a_sram_port : assert property (@(posedge clk) disable iff (!rst_n)
    !(sram_rd_en && sram_wr_en))
    else $error("data SRAM read and written in one cycle");

endmodule

bind cache_lookup_top cache_lookup_asserts i_cache_lookup_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .req_valid  (req_valid),
  .req        (req),
  .resp_valid (resp_valid),
  .sram_rd_en (do_lookup),
  .sram_wr_en (do_fill)
);

`default_nettype wire

//--- dv/tb_cache_lookup.sv
//--------------------------------------------------------------------------
// Directed testbench for the lookup cache, drives strobed requests, predicts
// every lookup response from a per-set model and checks it one cycle later
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_cache_lookup;

  localparam int unsigned num_sets    = 64;
  localparam int unsigned index_bits  = $clog2(num_sets);
  localparam int          drain_limit = 16;
  localparam int          num_random  = 240;
  // Random addresses keep two tag bits so that sets alias and hit often
  localparam int unsigned addr_mask   = (1 << (cache_pkg::OFFSET_BITS + index_bits + 2)) - 1;

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid;
  cache_pkg::cache_req_t  req;
  logic                   resp_valid;
  cache_pkg::cache_resp_t resp;

  // Reference model with one entry per set
  logic                   model_valid [num_sets];
  cache_pkg::addr_t       model_tag   [num_sets];
  cache_pkg::data_t       model_word  [num_sets];

  // Lookups in flight, with the expected response and the cycle they were driven
  cache_pkg::cache_resp_t exp_q   [$];
  int                     issue_q [$];

  int     cycle     = 0;
  int     errors    = 0;
  int     checks    = 0;
  int     tests_run = 0;
  int     test_base = 0;
  integer seed;

  cache_lookup_top #(
    .num_sets (num_sets)
  ) i_cache_lookup_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //--------------------------------------------------------------------------
  // Address split and compare tasks
  //--------------------------------------------------------------------------

  // Set index sits just above the byte offset
  function automatic int set_of(input cache_pkg::addr_t addr);
    return int'((addr >> cache_pkg::OFFSET_BITS) & (num_sets - 1));
  endfunction

  // Tag is everything above offset and index, kept at full address width
  function automatic cache_pkg::addr_t tag_of(input cache_pkg::addr_t addr);
    return addr >> (cache_pkg::OFFSET_BITS + index_bits);
  endfunction

  task automatic check_hit(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: resp.hit got 0x%0h expected 0x%0h", got, exp);
    end
  endtask

  task automatic check_resp(input cache_pkg::cache_resp_t got,
                            input cache_pkg::cache_resp_t exp);
    check_hit(got.hit, exp.hit);
    checks++;
    if (got.data !== exp.data) begin
      errors++;
      $display("error: resp.data got 0x%08h expected 0x%08h", got.data, exp.data);
    end
  endtask

  // Responses are sampled mid-cycle, away from the edge that drives them
  // A lookup driven after negedge k is accepted one edge later and shows at negedge k+2
  always @(negedge clk) begin
    cycle = cycle + 1;
    if (resp_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("a response arrived at cycle %0d with no lookup pending", cycle);
      end else begin
        if (issue_q[0] + 2 != cycle) begin
          errors++;
          $display("lookup driven at cycle %0d answered at cycle %0d, one cycle late or early",
                   issue_q[0], cycle);
        end
        check_resp(resp, exp_q[0]);
        void'(exp_q.pop_front());
        void'(issue_q.pop_front());
      end
    end
  end

  //--------------------------------------------------------------------------
  // Driver and model update
  //--------------------------------------------------------------------------

  // Drives one request for one cycle and updates the model in request order
  task automatic send_req(input cache_pkg::cache_op_e op, input cache_pkg::addr_t addr,
                          input cache_pkg::data_t wdata, input cache_pkg::byte_en_t be);
    cache_pkg::cache_req_t  r;
    cache_pkg::cache_resp_t e;
    int                     s;
    int                     b;
    r.op      = op;
    r.addr    = addr;
    r.wdata   = wdata;
    r.byte_en = be;
    s         = set_of(addr);
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= r;
    case (op)
      cache_pkg::op_lookup: begin
        e.hit  = model_valid[s] && (model_tag[s] == tag_of(addr));
        e.data = e.hit ? model_word[s] : '0;
        exp_q.push_back(e);
        issue_q.push_back(cycle);
      end
      cache_pkg::op_fill: begin
        // Only the enabled bytes of the stored word change
        for (b = 0; b < $bits(cache_pkg::byte_en_t); b++) begin
          if (be[b]) begin
            model_word[s][b*8 +: 8] = wdata[b*8 +: 8];
          end
        end
        model_valid[s] = 1'b1;
        model_tag[s]   = tag_of(addr);
      end
      cache_pkg::op_inval: begin
        model_valid[s] = 1'b0;
      end
      default: begin
      end
    endcase
  endtask

  task automatic idle_bus();
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  // Waits until every pending lookup has been answered
  task automatic drain_responses(input string name);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_limit) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("timeout: %0d lookup responses never arrived in test %s", exp_q.size(), name);
      exp_q.delete();
      issue_q.delete();
    end
  endtask

  task automatic start_test();
    test_base = errors;
  endtask

  task automatic end_test(input string name);
    idle_bus();
    drain_responses(name);
    tests_run++;
    $display("test %-14s %0d errors", name, errors - test_base);
  endtask

  //--------------------------------------------------------------------------
  // Directed tests
  //--------------------------------------------------------------------------

  task automatic test_reset_miss();
    start_test();
    send_req(cache_pkg::op_lookup, 16'h0000, '0, '0);
    send_req(cache_pkg::op_lookup, 16'h1234, '0, '0);
    send_req(cache_pkg::op_lookup, 16'h80fc, '0, '0);
    send_req(cache_pkg::op_lookup, 16'hfffc, '0, '0);
    end_test("reset_miss");
  endtask

  task automatic test_fill_hit();
    start_test();
    send_req(cache_pkg::op_fill, 16'h1234, 32'hdeadbeef, 4'hf);
    send_req(cache_pkg::op_lookup, 16'h1234, '0, '0);
    // Another byte of the same word hits as well
    send_req(cache_pkg::op_lookup, 16'h1236, '0, '0);
    end_test("fill_hit");
  endtask

  task automatic test_partial_merge();
    start_test();
    send_req(cache_pkg::op_fill, 16'h2040, 32'h11223344, 4'hf);
    send_req(cache_pkg::op_lookup, 16'h2040, '0, '0);
    send_req(cache_pkg::op_fill, 16'h2040, 32'haabbccdd, 4'b0101);
    send_req(cache_pkg::op_lookup, 16'h2040, '0, '0);
    send_req(cache_pkg::op_fill, 16'h2040, 32'h55667788, 4'b1000);
    send_req(cache_pkg::op_lookup, 16'h2040, '0, '0);
    end_test("partial_merge");
  endtask

  task automatic test_alias_evict();
    start_test();
    // Both addresses share index 4 and differ in the tag
    send_req(cache_pkg::op_fill, 16'h0310, 32'ha5a5a5a5, 4'hf);
    send_req(cache_pkg::op_lookup, 16'h0310, '0, '0);
    send_req(cache_pkg::op_fill, 16'h8310, 32'h5a5a0f0f, 4'hf);
    send_req(cache_pkg::op_lookup, 16'h0310, '0, '0);
    send_req(cache_pkg::op_lookup, 16'h8310, '0, '0);
    end_test("alias_evict");
  endtask

  task automatic test_inval_refill();
    start_test();
    send_req(cache_pkg::op_fill, 16'h4504, 32'h0badf00d, 4'hf);
    send_req(cache_pkg::op_lookup, 16'h4504, '0, '0);
    send_req(cache_pkg::op_inval, 16'h4504, '0, '0);
    send_req(cache_pkg::op_lookup, 16'h4504, '0, '0);
    send_req(cache_pkg::op_fill, 16'h4504, 32'hcafe1234, 4'hf);
    send_req(cache_pkg::op_lookup, 16'h4504, '0, '0);
    end_test("inval_refill");
  endtask

  task automatic test_random_stream();
    logic [31:0]      r;
    cache_pkg::addr_t a;
    int               i;
    start_test();
    // Every set gets a full word first so no byte stays unwritten
    for (i = 0; i < num_sets; i++) begin
      r = $random(seed);
      a = cache_pkg::addr_t'((r[1:0] << (cache_pkg::OFFSET_BITS + index_bits)) |
                             (i << cache_pkg::OFFSET_BITS));
      send_req(cache_pkg::op_fill, a, $random(seed), 4'hf);
    end
    // Half lookups, the rest fills with random byte enables and a few invalidates
    for (i = 0; i < num_random; i++) begin
      r = $random(seed);
      a = cache_pkg::addr_t'(r[15:0] & addr_mask);
      if (r[31:29] < 3'd4) begin
        send_req(cache_pkg::op_lookup, a, '0, '0);
      end else if (r[31:29] < 3'd7) begin
        send_req(cache_pkg::op_fill, a, $random(seed), r[19:16]);
      end else begin
        send_req(cache_pkg::op_inval, a, '0, '0);
      end
    end
    end_test("random_stream");
  endtask

  //--------------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------------

  initial begin
    int s;
    seed      = 45;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    for (s = 0; s < num_sets; s++) begin
      model_valid[s] = 1'b0;
      model_tag[s]   = '0;
      model_word[s]  = '0;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_miss();
    test_fill_hit();
    test_partial_merge();
    test_alias_evict();
    test_inval_refill();
    test_random_stream();

    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
rtl/cache_pkg.sv
rtl/sram_1rw.sv
rtl/tag_array.sv
rtl/hit_check.sv
rtl/cache_lookup_top.sv
dv/cache_lookup_asserts.sv
dv/tb_cache_lookup.sv

//--- Bender.yml
package:
  name: cache_lookup

sources:
  # Package first, then leaf blocks, then the top level
  - rtl/cache_pkg.sv
  - rtl/sram_1rw.sv
  - rtl/tag_array.sv
  - rtl/hit_check.sv
  - rtl/cache_lookup_top.sv

  # Verification sources
  - target: test
    files:
      - dv/cache_lookup_asserts.sv
      - dv/tb_cache_lookup.sv
